/* Bender.yml */
package:
  name: ooo_retire

sources:
  - include_dirs:
      - include
    files:
      - design/rob_pkg.sv
      - design/rob_if.sv
      - design/rename_table.sv
      - design/reservation_station.sv
      - design/exec_unit.sv
      - design/rob.sv
      - design/ooo_retire_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ooo_retire_chk.sv
      - test/ooo_retire_tb.sv

/* design/exec_unit.sv */
`default_nettype none

module exec_unit import rob_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  issue_valid,
    input  op_e   issue_op,
    input  word_t issue_a,
    input  word_t issue_b,
    input  tag_t  issue_tag,
    input  word_t issue_pc,
    input  word_t issue_imm,
    input  logic  issue_pred,
    output logic  issue_ready,
    cdb_if.source cdb
);

    logic  is_mul;
    logic  fire;
    logic  br_taken;
    word_t alu_result;
    logic  alu_valid;
    tag_t  alu_tag;
    word_t alu_data;
    logic  alu_taken;
    word_t alu_target;
    logic [2:0] mul_valid;
    tag_t  mul_tag  [3];
    word_t mul_data [3];

    assign is_mul = issue_op == OP_MUL;
    // a mul in stage 1 owns the bus next cycle
    assign issue_ready = is_mul || !mul_valid[1];
    assign fire = issue_valid && issue_ready;

    always_comb begin
        br_taken   = 1'b0;
        alu_result = '0;
        case (issue_op)
            OP_ADD: alu_result = issue_a + issue_b;
            OP_SUB: alu_result = issue_a - issue_b;
            OP_XOR: alu_result = issue_a ^ issue_b;
            OP_BEQ, OP_BNE: begin
                br_taken = (issue_op == OP_BEQ) ? (issue_a == issue_b) : (issue_a != issue_b);
                // branch word flags a mispredict, handy in waves
                alu_result = word_t'(br_taken ^ issue_pred);
            end
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid <= fire && !is_mul;
            mul_valid <= {mul_valid[1:0], fire && is_mul};
        end
    end

    always_ff @(posedge clk) begin
        alu_tag     <= issue_tag;
        alu_data    <= alu_result;
        alu_taken   <= br_taken;
        alu_target  <= issue_pc + issue_imm;
        mul_tag[0]  <= issue_tag;
        mul_data[0] <= issue_a * issue_b;
        for (int s = 1; s < 3; s++) begin
            mul_tag[s]  <= mul_tag[s-1];
            mul_data[s] <= mul_data[s-1];
        end
    end

    assign cdb.valid  = alu_valid || mul_valid[2];
    assign cdb.tag    = mul_valid[2] ? mul_tag[2] : alu_tag;
    assign cdb.data   = mul_valid[2] ? mul_data[2] : alu_data;
    assign cdb.taken  = !mul_valid[2] && alu_taken;
    assign cdb.target = alu_target;

endmodule

`default_nettype wire

/* design/ooo_retire_top.sv */
`default_nettype none

module ooo_retire_top import rob_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  op_e   in_op,
    input  reg_t  in_rd,
    input  reg_t  in_rs1,
    input  reg_t  in_rs2,
    input  word_t in_pc,
    input  word_t in_imm,
    input  logic  in_pred_taken,
    output logic  in_ready,
    output logic  commit_valid,
    output reg_t  commit_rd,
    output word_t commit_data,
    output word_t commit_pc,
    output logic  flush,
    output word_t flush_pc
);

    cdb_if    cdb_bus ();
    commit_if commit_bus ();

    logic     rob_full;
    logic     rs_full;
    logic     alloc;
    logic     is_branch;
    tag_t     tail_tag;
    operand_t src1;
    operand_t src2;
    logic     issue_valid;
    logic     issue_ready;
    op_e      issue_op;
    word_t    issue_a;
    word_t    issue_b;
    tag_t     issue_tag;
    word_t    issue_pc;
    word_t    issue_imm;
    logic     issue_pred;

    // state only, never looks at in_valid
    assign in_ready  = !reset && !rob_full && !rs_full && !flush;
    assign alloc     = in_valid && in_ready;
    assign is_branch = (in_op == OP_BEQ) || (in_op == OP_BNE);

    rename_table rename_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .rs1       (in_rs1),
        .rs2       (in_rs2),
        .rd        (in_rd),
        .alloc     (alloc && !is_branch && in_rd != '0),
        .alloc_tag (tail_tag),
        .src1      (src1),
        .src2      (src2),
        .cdb       (cdb_bus.sink),
        .commit    (commit_bus.sink)
    );

    reservation_station rs_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .in_valid      (alloc),
        .in_op         (in_op),
        .src1          (src1),
        .src2          (src2),
        .in_tag        (tail_tag),
        .in_pc         (in_pc),
        .in_imm        (in_imm),
        .in_pred_taken (in_pred_taken),
        .full          (rs_full),
        .cdb           (cdb_bus.sink),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_pc      (issue_pc),
        .issue_imm     (issue_imm),
        .issue_pred    (issue_pred),
        .issue_ready   (issue_ready)
    );

    exec_unit exec_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag),
        .issue_pc    (issue_pc),
        .issue_imm   (issue_imm),
        .issue_pred  (issue_pred),
        .issue_ready (issue_ready),
        .cdb         (cdb_bus.source)
    );

    rob rob_i (
        .clk              (clk),
        .reset            (reset),
        .alloc_valid      (alloc),
        .alloc_pc         (in_pc),
        .alloc_rd         (in_rd),
        .alloc_pred_taken (in_pred_taken),
        .alloc_is_branch  (is_branch),
        .tail_tag         (tail_tag),
        .full             (rob_full),
        .cdb              (cdb_bus.sink),
        .commit           (commit_bus.source),
        .commit_pc        (commit_pc),
        .flush            (flush),
        .flush_pc         (flush_pc)
    );

    assign commit_valid = commit_bus.valid;
    assign commit_rd    = commit_bus.rd;
    assign commit_data  = commit_bus.data;

endmodule

`default_nettype wire

/* design/rename_table.sv */
`default_nettype none

`include "rob_consts.svh"

module rename_table import rob_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  reg_t     rs1,
    input  reg_t     rs2,
    input  reg_t     rd,
    input  logic     alloc,
    input  tag_t     alloc_tag,
    output operand_t src1,
    output operand_t src2,
    cdb_if.sink      cdb,
    commit_if.sink   commit
);

    word_t arch [`NUM_REGS];
    // results already broadcast but not yet retired
    word_t spec [`NUM_REGS];
    tag_t  pend_tag [`NUM_REGS];
    logic [`NUM_REGS-1:0] pending;
    logic [`NUM_REGS-1:0] spec_done;

    // a retiring tag was broadcast earlier, so spec already holds its value
    function automatic operand_t lookup(reg_t r);
        operand_t op;
        op.ready = 1'b1;
        op.tag   = pend_tag[r];
        op.value = arch[r];
        if (r == '0) begin
            op.value = '0;
        end else if (pending[r]) begin
            if (spec_done[r]) begin
                op.value = spec[r];
            end else begin
                op.ready = 1'b0;
            end
        end
        return op;
    endfunction

    assign src1 = lookup(rs1);
    assign src2 = lookup(rs2);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending   <= '0;
            spec_done <= '0;
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (cdb.valid && pending[i] && pend_tag[i] == cdb.tag) begin
                    spec_done[i] <= 1'b1;
                end
            end
            // only the youngest writer clears the flag
            if (commit.valid && pending[commit.rd] && pend_tag[commit.rd] == commit.tag) begin
                pending[commit.rd] <= 1'b0;
            end
            if (alloc) begin
                pending[rd]   <= 1'b1;
                spec_done[rd] <= 1'b0;
            end
            if (flush) begin
                pending   <= '0;
                spec_done <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_REGS; i++) begin
            if (cdb.valid && pending[i] && pend_tag[i] == cdb.tag) begin
                spec[i] <= cdb.data;
            end
        end
        if (commit.valid && commit.rd != '0) begin
            arch[commit.rd] <= commit.data;
        end
        if (alloc) begin
            pend_tag[rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

/* design/reservation_station.sv */
`default_nettype none

`include "rob_consts.svh"

module reservation_station import rob_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  op_e      in_op,
    input  operand_t src1,
    input  operand_t src2,
    input  tag_t     in_tag,
    input  word_t    in_pc,
    input  word_t    in_imm,
    input  logic     in_pred_taken,
    output logic     full,
    cdb_if.sink      cdb,
    output logic     issue_valid,
    output op_e      issue_op,
    output word_t    issue_a,
    output word_t    issue_b,
    output tag_t     issue_tag,
    output word_t    issue_pc,
    output word_t    issue_imm,
    output logic     issue_pred,
    input  logic     issue_ready
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] valid;
    // older[i][j] set when entry j was allocated before entry i
    logic [`RS_DEPTH-1:0] older [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] ready;
    logic [`RS_DEPTH-1:0] e_pred;
    op_e      e_op  [`RS_DEPTH];
    operand_t e_a   [`RS_DEPTH];
    operand_t e_b   [`RS_DEPTH];
    tag_t     e_tag [`RS_DEPTH];
    word_t    e_pc  [`RS_DEPTH];
    word_t    e_imm [`RS_DEPTH];
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic fire;

    function automatic operand_t capture(operand_t op);
        operand_t res;
        res = op;
        if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb.data;
        end
        return res;
    endfunction

    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = valid[i] && e_a[i].ready && e_b[i].ready;
        end
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = IDX_W'(i);
        end
        // oldest ready entry has no older ready entry
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ready[i] && !(|(older[i] & ready))) sel_idx = IDX_W'(i);
        end
    end

    assign full        = &valid;
    assign issue_valid = |ready;
    assign fire        = issue_valid && issue_ready;

    assign issue_op   = e_op[sel_idx];
    assign issue_a    = e_a[sel_idx].value;
    assign issue_b    = e_b[sel_idx].value;
    assign issue_tag  = e_tag[sel_idx];
    assign issue_pc   = e_pc[sel_idx];
    assign issue_imm  = e_imm[sel_idx];
    assign issue_pred = e_pred[sel_idx];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            if (fire) valid[sel_idx] <= 1'b0;
            if (in_valid) begin
                valid[free_idx] <= 1'b1;
                older[free_idx] <= valid;
                for (int j = 0; j < `RS_DEPTH; j++) begin
                    if (j != int'(free_idx)) older[j][free_idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            e_a[i] <= capture(e_a[i]);
            e_b[i] <= capture(e_b[i]);
        end
        if (in_valid) begin
            e_op[free_idx]   <= in_op;
            e_a[free_idx]    <= capture(src1);
            e_b[free_idx]    <= capture(src2);
            e_tag[free_idx]  <= in_tag;
            e_pc[free_idx]   <= in_pc;
            e_imm[free_idx]  <= in_imm;
            e_pred[free_idx] <= in_pred_taken;
        end
    end

endmodule

`default_nettype wire

/* design/rob.sv */
`default_nettype none

`include "rob_consts.svh"

module rob import rob_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     alloc_valid,
    input  word_t    alloc_pc,
    input  reg_t     alloc_rd,
    input  logic     alloc_pred_taken,
    input  logic     alloc_is_branch,
    output tag_t     tail_tag,
    output logic     full,
    cdb_if.sink      cdb,
    commit_if.source commit,
    output word_t    commit_pc,
    output logic     flush,
    output word_t    flush_pc
);

    tag_t head;
    tag_t tail;
    logic [`TAG_W:0] count;
    logic [`ROB_DEPTH-1:0] done;

    reg_t  e_rd     [`ROB_DEPTH];
    word_t e_pc     [`ROB_DEPTH];
    logic  e_pred   [`ROB_DEPTH];
    logic  e_br     [`ROB_DEPTH];
    word_t e_data   [`ROB_DEPTH];
    logic  e_taken  [`ROB_DEPTH];
    word_t e_target [`ROB_DEPTH];

    logic retire;

    assign tail_tag = tail;
    assign full     = count == (`TAG_W + 1)'(`ROB_DEPTH);

    // head retires once its result is back
    assign retire = (count != '0) && done[head];

    assign commit.valid = retire;
    assign commit.rd    = e_rd[head];
    assign commit.tag   = head;
    assign commit.data  = e_data[head];
    assign commit_pc    = e_pc[head];

    assign flush    = retire && e_br[head] && (e_taken[head] != e_pred[head]);
    assign flush_pc = e_taken[head] ? e_target[head] : e_pc[head] + `XLEN'd4;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (`TAG_W + 1)'(alloc_valid) - (`TAG_W + 1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            // branches never write a register
            e_rd[tail]   <= alloc_is_branch ? '0 : alloc_rd;
            e_pc[tail]   <= alloc_pc;
            e_pred[tail] <= alloc_pred_taken;
            e_br[tail]   <= alloc_is_branch;
        end
        if (cdb.valid) begin
            e_data[cdb.tag]   <= cdb.data;
            e_taken[cdb.tag]  <= cdb.taken;
            e_target[cdb.tag] <= cdb.target;
        end
    end

endmodule

`default_nettype wire

/* design/rob_if.sv */
`default_nettype none

// result broadcast, always accepted by its sinks
interface cdb_if import rob_pkg::*; ();
    logic  valid;
    tag_t  tag;
    word_t data;
    logic  taken;
    word_t target;

    modport source (
        output valid, tag, data, taken, target
    );

    modport sink (
        input valid, tag, data, taken, target
    );
endinterface

// in-order retirement write
interface commit_if import rob_pkg::*; ();
    logic  valid;
    reg_t  rd;
    tag_t  tag;
    word_t data;

    modport source (
        output valid, rd, tag, data
    );

    modport sink (
        input valid, rd, tag, data
    );
endinterface

`default_nettype wire

/* design/rob_pkg.sv */
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        OP_BEQ = 3'd4,
        OP_BNE = 3'd5
    } op_e;

    // tag only meaningful while ready is low
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t value;
    } operand_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+include
design/rob_pkg.sv
design/rob_if.sv
design/rename_table.sv
design/reservation_station.sv
design/exec_unit.sv
design/rob.sv
design/ooo_retire_top.sv
test/ooo_retire_chk.sv
test/ooo_retire_tb.sv

/* include/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// data and pc width
`define XLEN 32

// architectural registers, x0 hardwired to zero
`define NUM_REGS 32

// reorder entries, one tag per entry
`define ROB_DEPTH 16
`define TAG_W 4

// reservation station entries
`define RS_DEPTH 4

`endif

/* test/ooo_retire_chk.sv */
`default_nettype none

module ooo_retire_chk (
    input logic clk,
    input logic reset,
    input logic in_ready,
    input logic flush,
    input logic commit_valid,
    input logic alu_valid,
    input logic mul_done
);

    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    // nothing new may enter while the pipeline is being flushed
    property no_accept_in_flush;
        @(posedge clk) disable iff (reset) flush |-> !in_ready;
    endproperty

    property flush_with_commit;
        @(posedge clk) disable iff (reset) flush |-> commit_valid;
    endproperty

    // alu result and mul stage 3 share the one data bus
    property single_broadcast;
        @(posedge clk) disable iff (reset) !(alu_valid && mul_done);
    endproperty

    property ready_low_in_reset;
        @(posedge clk) reset |-> !in_ready;
    endproperty

    // first reset edge still sees unknown state
    property quiet_in_reset;
        @(posedge clk) reset ##1 reset |-> !commit_valid && !flush;
    endproperty

    no_accept_in_flush_a: assert property (no_accept_in_flush)
        else begin
            $error("in_ready high while flush is asserted");
            fails++;
        end
    flush_with_commit_a: assert property (flush_with_commit)
        else begin
            $error("flush raised without a retirement");
            fails++;
        end
    single_broadcast_a: assert property (single_broadcast)
        else begin
            $error("two results on the data bus in one cycle");
            fails++;
        end
    ready_low_in_reset_a: assert property (ready_low_in_reset)
        else begin
            $error("in_ready high during reset");
            fails++;
        end
    quiet_in_reset_a: assert property (quiet_in_reset)
        else begin
            $error("retirement or flush during reset");
            fails++;
        end

endmodule

`default_nettype wire

/* test/ooo_retire_tb.sv */
`default_nettype none

`include "rob_consts.svh"

module ooo_retire_tb import rob_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        op_e   op;
        reg_t  rd;
        reg_t  rs1;
        reg_t  rs2;
        word_t pc;
        word_t imm;
        logic  pred;
        logic  burst;
    } instr_t;

    typedef struct packed {
        logic  taken;
        word_t data;
        word_t target;
    } result_t;

    typedef struct packed {
        reg_t  rd;
        word_t data;
        word_t pc;
        logic  is_branch;
        logic  flush;
        word_t flush_pc;
    } expect_t;

    logic  clk;
    logic  reset;
    logic  in_valid;
    op_e   in_op;
    reg_t  in_rd;
    reg_t  in_rs1;
    reg_t  in_rs2;
    word_t in_pc;
    word_t in_imm;
    logic  in_pred_taken;
    logic  in_ready;
    logic  commit_valid;
    reg_t  commit_rd;
    word_t commit_data;
    word_t commit_pc;
    logic  flush;
    word_t flush_pc;

    instr_t  prog [$];
    expect_t expected [$];
    expect_t head_exp;
    word_t   model_regs [`NUM_REGS];
    instr_t  cur;
    logic    cur_valid = 1'b0;
    logic    wrong_path = 1'b0;
    word_t   model_pc = 32'h0000_1000;
    word_t   wrong_pc = '0;
    int      idx = 0;
    int      errors = 0;
    int      retired = 0;
    int      sent = 0;
    int      cycles = 0;
    int      held_cycles = 0;
    int      mispredicts = 0;
    int      good_branches = 0;

    always #50 clk = ~clk;

    ooo_retire_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_pc         (in_pc),
        .in_imm        (in_imm),
        .in_pred_taken (in_pred_taken),
        .in_ready      (in_ready),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data),
        .commit_pc     (commit_pc),
        .flush         (flush),
        .flush_pc      (flush_pc)
    );

    bind ooo_retire_top ooo_retire_chk chk_i (
        .clk          (clk),
        .reset        (reset),
        .in_ready     (in_ready),
        .flush        (flush),
        .commit_valid (commit_valid),
        .alu_valid    (exec_i.alu_valid),
        .mul_done     (exec_i.mul_valid[2])
    );

    task automatic check_value(string what, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic result_t reference(op_e op, word_t a, word_t b, word_t pc, word_t imm);
        result_t r;
        logic [2*`XLEN-1:0] prod;
        prod     = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        r.taken  = 1'b0;
        r.data   = '0;
        r.target = pc + imm;
        case (op)
            OP_ADD:  r.data = a + b;
            OP_SUB:  r.data = a - b;
            OP_XOR:  r.data = a ^ b;
            OP_MUL:  r.data = prod[`XLEN-1:0];
            OP_BEQ:  r.taken = a == b;
            OP_BNE:  r.taken = a != b;
            default: r.data = '0;
        endcase
        return r;
    endfunction

    // small register range keeps dependences frequent
    function automatic instr_t draw_instr();
        instr_t ins;
        int unsigned kind;
        ins  = '0;
        kind = $urandom_range(9, 0);
        case (kind)
            0, 1:    ins.op = OP_ADD;
            2:       ins.op = OP_SUB;
            3:       ins.op = OP_XOR;
            4, 5:    ins.op = OP_MUL;
            6, 7:    ins.op = OP_BEQ;
            default: ins.op = OP_BNE;
        endcase
        ins.rd   = reg_t'($urandom_range(7, 0));
        ins.rs1  = reg_t'($urandom_range(7, 0));
        ins.rs2  = reg_t'($urandom_range(7, 0));
        ins.imm  = word_t'($urandom_range(63, 1)) << 2;
        ins.pred = 1'($urandom_range(1, 0));
        return ins;
    endfunction

    task automatic present_next();
        instr_t ins;
        cur_valid = 1'b1;
        if (wrong_path) begin
            ins      = draw_instr();
            ins.pc   = wrong_pc;
            wrong_pc = wrong_pc + 4;
        end else if (idx < prog.size()) begin
            ins    = prog[idx];
            ins.pc = model_pc;
        end else begin
            ins       = '0;
            cur_valid = 1'b0;
        end
        cur = ins;
        in_valid      <= cur_valid;
        in_op         <= ins.op;
        in_rd         <= ins.rd;
        in_rs1        <= ins.rs1;
        in_rs2        <= ins.rs2;
        in_pc         <= ins.pc;
        in_imm        <= ins.imm;
        in_pred_taken <= ins.pred;
    endtask

    // model state advances in program order at acceptance
    task automatic accept_correct();
        expect_t e;
        result_t r;
        logic    br;
        br = (cur.op == OP_BEQ) || (cur.op == OP_BNE);
        r  = reference(cur.op, model_regs[cur.rs1], model_regs[cur.rs2], cur.pc, cur.imm);
        e.rd        = br ? '0 : cur.rd;
        e.data      = r.data;
        e.pc        = cur.pc;
        e.is_branch = br;
        e.flush     = br && (r.taken != cur.pred);
        e.flush_pc  = r.taken ? r.target : cur.pc + 4;
        expected.push_back(e);
        if (!br && cur.rd != '0) begin
            model_regs[cur.rd] = r.data;
        end
        idx++;
        model_pc = (br && r.taken) ? r.target : cur.pc + 4;
        if (e.flush) begin
            mispredicts++;
            wrong_path = 1'b1;
            // younger work follows the predicted path until the flush
            wrong_pc = r.taken ? cur.pc + 4 : r.target;
        end else if (br) begin
            good_branches++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            if (expected.size() == 0) begin
                errors++;
                $display("ERR at %0t: retirement of pc %h with none expected", $time, commit_pc);
            end else begin
                head_exp = expected.pop_front();
                retired++;
                check_value("commit_rd", word_t'(commit_rd), word_t'(head_exp.rd));
                if (!head_exp.is_branch) begin
                    check_value("commit_data", commit_data, head_exp.data);
                end
                check_value("commit_pc", commit_pc, head_exp.pc);
                check_value("flush", word_t'(flush), word_t'(head_exp.flush));
                if (head_exp.flush) begin
                    check_value("flush_pc", flush_pc, head_exp.flush_pc);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles <= 40 * sent + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation timed out after %0d cycles with %0d retirements outstanding",
                 cycles, expected.size());
        $display("errors: %0d  retired: %0d", errors + dut_i.chk_i.fails, retired);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        instr_t ins;
        logic   accepted;
        logic   saw_flush;
        void'($urandom(32'h32e7_234b));
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = OP_ADD;
        in_rd         = '0;
        in_rs1        = '0;
        in_rs2        = '0;
        in_pc         = '0;
        in_imm        = '0;
        in_pred_taken = 1'b0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        // arch registers power up unknown, so clear x1..x7 first
        for (int r = 1; r < 8; r++) begin
            ins    = '0;
            ins.op = OP_ADD;
            ins.rd = reg_t'(r);
            prog.push_back(ins);
        end
        repeat (80) prog.push_back(draw_instr());
        // serial mul chain interleaved with independent muls
        for (int i = 0; i < 40; i++) begin
            ins       = '0;
            ins.op    = OP_MUL;
            ins.burst = 1'b1;
            ins.rd    = (i % 2 == 0) ? reg_t'(1) : reg_t'(3 + i % 3);
            ins.rs1   = (i % 2 == 0) ? reg_t'(1) : reg_t'(6);
            ins.rs2   = (i % 2 == 0) ? reg_t'(2) : reg_t'(7);
            prog.push_back(ins);
        end
        repeat (20) prog.push_back(draw_instr());

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("in_ready after reset", word_t'(in_ready), 1);
        repeat (4) begin
            @(negedge clk);
            check_value("idle commit_valid", word_t'(commit_valid), 0);
            check_value("idle flush", word_t'(flush), 0);
        end

        @(posedge clk);
        present_next();
        while (cur_valid || wrong_path) begin
            @(negedge clk);
            accepted  = in_valid && in_ready;
            saw_flush = flush;
            if (cur_valid && cur.burst && !in_ready) begin
                held_cycles++;
            end
            @(posedge clk);
            if (saw_flush) begin
                wrong_path = 1'b0;
                present_next();
            end else if (accepted) begin
                sent++;
                if (!wrong_path) begin
                    accept_correct();
                end
                present_next();
            end
        end

        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // flushed work must never show up later
        repeat (2 * `ROB_DEPTH) @(negedge clk);

        if (held_cycles == 0) begin
            errors++;
            $display("the multiply run never held an instruction at the input");
        end
        if (mispredicts == 0 || good_branches == 0) begin
            errors++;
            $display("branch mix incomplete: %0d mispredicted, %0d predicted correctly",
                     mispredicts, good_branches);
        end
        errors += dut_i.chk_i.fails;
        $display("errors: %0d  retired: %0d  mispredicts: %0d  held cycles: %0d",
                 errors, retired, mispredicts, held_cycles);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
